//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  word_t     aluop1,
    input  word_t     aluop2,
    input  alu_ctrl_e aluctrl,
    output word_t     aluout,
    output logic      eq
);

    logic [4:0] shamt;

    assign shamt = aluop2[4:0];    // only low five bits count

    always_comb begin
        case (aluctrl)
            alu_add: begin
                aluout = aluop1 + aluop2;
            end
            alu_sub: begin
                aluout = aluop1 - aluop2;
            end
            alu_and: begin
                aluout = aluop1 & aluop2;
            end
            alu_or: begin
                aluout = aluop1 | aluop2;
            end
            alu_xor: begin
                aluout = aluop1 ^ aluop2;
            end
            alu_slt: begin
                aluout = {{(xlen-1){1'b0}}, $signed(aluop1) < $signed(aluop2)};
            end
            alu_sltu: begin
                aluout = {{(xlen-1){1'b0}}, aluop1 < aluop2};
            end
            alu_sll: begin
                aluout = aluop1 << shamt;
            end
            alu_srl: begin
                aluout = aluop1 >> shamt;
            end
            alu_sra: begin
                aluout = word_t'($signed(aluop1) >>> shamt);  // sign fill
            end
            default: begin
                aluout = '0;
            end
        endcase
    end

    // flag meaning depends on the operation, branches rely on sub/slt/sltu
    always_comb begin
        case (aluctrl)
            alu_sub:                                   eq = (aluout == '0);
            alu_slt, alu_sltu, alu_and, alu_or, alu_xor: eq = (aluout == word_t'(1));
            default:                                   eq = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
    import rv_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl
);

    opcode_t opcode;
    funct3_t funct3;
    logic    bit30;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_b;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];    // sub and sra select

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl.alu_op        = alu_add;
        ctrl.rs1           = instr[19:15];
        ctrl.rs2           = instr[24:20];
        ctrl.rd            = instr[11:7];
        ctrl.imm           = imm_i;
        ctrl.use_imm       = 1'b0;
        ctrl.zero_op1      = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.is_branch     = 1'b0;
        ctrl.branch_invert = 1'b0;

        case (opcode)
            op_op, op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = (opcode == op_imm);
                case (funct3)
                    f3_add_sub: begin
                        // no subtract form exists for immediates
                        if (opcode == op_op && bit30) begin
                            ctrl.alu_op = alu_sub;
                        end else begin
                            ctrl.alu_op = alu_add;
                        end
                    end
                    f3_sll:  ctrl.alu_op = alu_sll;
                    f3_slt:  ctrl.alu_op = alu_slt;
                    f3_sltu: ctrl.alu_op = alu_sltu;
                    f3_xor:  ctrl.alu_op = alu_xor;
                    f3_srl_sra: begin
                        ctrl.alu_op = bit30 ? alu_sra : alu_srl;
                    end
                    f3_or:   ctrl.alu_op = alu_or;
                    f3_and:  ctrl.alu_op = alu_and;
                    default: ctrl.alu_op = alu_add;
                endcase
            end

            op_lui: begin
                ctrl.alu_op    = alu_add;    // 0 + imm
                ctrl.imm       = imm_u;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_op1  = 1'b1;
                ctrl.reg_write = 1'b1;
            end

            op_branch: begin
                ctrl.imm       = imm_b;
                ctrl.rd        = '0;         // branches retire with rd 0
                ctrl.is_branch = 1'b1;
                case (funct3)
                    f3_beq: begin
                        ctrl.alu_op = alu_sub;
                    end
                    f3_bne: begin
                        ctrl.alu_op        = alu_sub;
                        ctrl.branch_invert = 1'b1;
                    end
                    f3_blt: begin
                        ctrl.alu_op = alu_slt;
                    end
                    f3_bge: begin
                        ctrl.alu_op        = alu_slt;
                        ctrl.branch_invert = 1'b1;
                    end
                    f3_bltu: begin
                        ctrl.alu_op = alu_sltu;
                    end
                    f3_bgeu: begin
                        ctrl.alu_op        = alu_sltu;
                        ctrl.branch_invert = 1'b1;
                    end
                    default: begin
                        ctrl.is_branch = 1'b0;  // reserved funct3, never taken
                    end
                endcase
            end

            default: begin
                ctrl.rd = '0;    // unknown opcode does nothing
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  taken,
    input  word_t offset,
    output word_t pc
);

    localparam word_t insn_bytes = word_t'(4);

    word_t pc_q;
    word_t pc_seq;
    word_t pc_target;
    word_t pc_next;

    assign pc_seq    = pc_q + insn_bytes;
    assign pc_target = pc_q + offset;    // b-type offset, already doubled

    always_comb begin
        if (taken) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wdata
);

    localparam int num_regs = 2 ** reg_addr_w;

    word_t regs [1:num_regs-1];    // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // plain reads, a write lands at the next edge
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  instr_t  instr,
    output word_t   pc,
    output retire_t retire
);

    ctrl_t ctrl;
    word_t rdata1;
    word_t rdata2;
    word_t op1;
    word_t op2;
    word_t alu_result;
    logic  alu_eq;
    logic  taken;

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (ctrl.reg_write),
        .rd     (ctrl.rd),
        .wdata  (alu_result)
    );

    // operand muxes
    assign op1 = ctrl.zero_op1 ? '0 : rdata1;     // lui adds to zero
    assign op2 = ctrl.use_imm ? ctrl.imm : rdata2;

    alu u_alu (
        .aluop1  (op1),
        .aluop2  (op2),
        .aluctrl (ctrl.alu_op),
        .aluout  (alu_result),
        .eq      (alu_eq)
    );

    assign taken = ctrl.is_branch & (alu_eq ^ ctrl.branch_invert);

    pc_unit u_pc_unit (
        .clk    (clk),
        .reset  (reset),
        .taken  (taken),
        .offset (ctrl.imm),
        .pc     (pc)
    );

    // trace of the instruction executing this cycle
    always_comb begin
        retire.valid        = !reset && (ctrl.reg_write || ctrl.is_branch);
        retire.rd           = ctrl.rd;
        retire.data         = alu_result;
        retire.branch_taken = taken;
    end

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;    // fixed by the encoding
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;

    // major opcodes of the supported subset
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_branch = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // funct3 for branches
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_ctrl_e;

    typedef struct packed {
        alu_ctrl_e alu_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        logic      use_imm;        // operand two from imm
        logic      zero_op1;       // operand one forced to zero
        logic      reg_write;
        logic      is_branch;
        logic      branch_invert;  // bne, bge, bgeu
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
        logic      branch_taken;
    } retire_t;

endpackage

`default_nettype wire

//--- rv_core.f
+incdir+sim
rtl/rv_pkg.sv
rtl/alu.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/pc_unit.sv
rtl/rv_core.sv
sim/rv_core_tb.sv

//--- sim/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

word_t model_regs [0:31];    // architectural registers, x0 included
word_t model_pc;

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    model_pc = '0;
endtask

// runs one instruction on the ISA model, returns the record the core should retire
task automatic model_step(input instr_t ins, output retire_t expected, output string name);
    word_t              a;
    word_t              b;
    word_t              res;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               taken;
    a        = model_regs[ins[19:15]];
    b        = model_regs[ins[24:20]];
    res      = '0;
    taken    = 1'b0;
    name     = "illegal";
    expected = '0;
    if (ins[6:0] == op_imm) begin
        b = {{20{ins[31]}}, ins[31:20]};    // I-type immediate
    end
    sa = a;
    sb = b;
    case (ins[6:0])
        op_op, op_imm: begin
            name = (ins[6:0] == op_op) ? "op" : "op_imm";
            case (ins[14:12])
                3'b000: res = (ins[6:0] == op_op && ins[30]) ? a - b : a + b;
                3'b001: res = a << b[4:0];
                3'b010: res = word_t'(sa < sb);
                3'b011: res = word_t'(a < b);
                3'b100: res = a ^ b;
                3'b101: res = ins[30] ? word_t'(sa >>> b[4:0]) : a >> b[4:0];
                3'b110: res = a | b;
                default: res = a & b;
            endcase
        end
        op_lui: begin
            name = "lui";
            res  = {ins[31:12], 12'b0};
        end
        op_branch: begin
            name = "branch";
            case (ins[14:12])
                3'b000: taken = (a == b);
                3'b001: taken = (a != b);
                3'b100: taken = (sa < sb);
                3'b101: taken = (sa >= sb);
                3'b110: taken = (a < b);
                3'b111: taken = (a >= b);
                default: name = "illegal";    // reserved funct3
            endcase
            if (!ins[14]) begin
                res = a - b;    // beq/bne compare by subtraction
            end else if (!ins[13]) begin
                res = word_t'(sa < sb);
            end else begin
                res = word_t'(a < b);
            end
        end
        default: name = "illegal";
    endcase
    expected.valid        = (name != "illegal");
    expected.rd           = (name == "branch") ? reg_addr_t'(0) : ins[11:7];
    expected.data         = res;
    expected.branch_taken = taken;
    if (expected.valid && name != "branch" && ins[11:7] != 5'd0) begin
        model_regs[ins[11:7]] = res;
    end
    if (taken) begin
        model_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    end else begin
        model_pc = model_pc + 32'd4;
    end
endtask

`endif

//--- sim/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb
    import rv_pkg::*;
();

    localparam int     clk_period = 100;
    localparam int     prog_len   = 200;
    localparam int     max_cycles = 260;            // program length plus margin
    localparam instr_t nop        = 32'h0000_0013;  // addi x0, x0, 0

    logic    clk;
    logic    reset;
    instr_t  instr;
    word_t   pc;
    retire_t retire;
    instr_t  prog [0:prog_len-1];
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;

    `include "rv_model.svh"

    rv_core DUT (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic instr_t fetch(input word_t addr);
        if (addr[1:0] == 2'b00 && addr < word_t'(prog_len * 4)) begin
            return prog[addr[9:2]];
        end
        return nop;    // outside the program
    endfunction

    always_comb instr = fetch(pc);

    function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input funct3_t f3,
                                      input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                      input funct3_t f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic instr_t u_type(input logic [19:0] upper, input reg_addr_t rd);
        return {upper, rd, op_lui};
    endfunction

    function automatic instr_t b_type(input logic [12:0] off, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic build_program();
        int        n;
        int        kind;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        funct3_t   f3;
        word_t     value;
        n = 0;
        while (n < prog_len) begin
            kind  = $urandom % 16;
            rd    = reg_addr_t'($urandom);    // x0 now and then
            rs1   = reg_addr_t'($urandom);
            rs2   = reg_addr_t'($urandom);
            f3    = funct3_t'($urandom);
            value = $urandom;
            if (kind < 3 && n < prog_len - 1) begin
                prog[n]     = u_type(value[31:12], rd);
                prog[n + 1] = i_type(value[11:0], rd, f3_add_sub, rd);
                n += 2;
            end else if (kind < 8) begin
                prog[n] = r_type((value[30] && (f3 == f3_add_sub || f3 == f3_srl_sra)) ?
                                 7'h20 : 7'h00, rs2, rs1, f3, rd);
                n++;
            end else if (kind < 12) begin
                if (f3 == f3_sll || f3 == f3_srl_sra) begin
                    value[11:5] = (f3 == f3_srl_sra && value[30]) ? 7'h20 : 7'h00;  // shamt form
                end
                prog[n] = i_type(value[11:0], rs1, f3, rd);
                n++;
            end else if (kind < 15) begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;    // no reserved branch funct3
                end
                if (value[1:0] == 2'b00) begin
                    rs2 = rs1;
                end
                prog[n] = b_type(value[2] ? 13'd12 : 13'd8, rs2, rs1, f3);
                n++;
            end else begin
                case (value[1:0])
                    2'd0: prog[n] = {value[31:7], 7'h03};       // load
                    2'd1: prog[n] = {value[31:7], 7'h23};       // store
                    2'd2: prog[n] = {value[31:7], 7'h6f};       // jal
                    default: prog[n] = {value[31:7], 7'h73};    // system
                endcase
                n++;
            end
        end
    endtask

    initial begin
        retire_t expected;
        string   name;
        reset = 1'b1;
        void'($urandom(90));
        build_program();
        model_reset();
        @(posedge clk);
        @(negedge clk);
        #(clk_period / 4);
        check_value("reset pc", 64'(0), 64'(pc));
        check_value("reset valid", 64'(0), 64'(retire.valid));
        @(negedge clk);
        reset = 1'b0;    // two rising edges seen in reset
        while (model_pc < word_t'(prog_len * 4)) begin
            #(clk_period / 4);    // settled, well before the rising edge
            check_value("pc", 64'(model_pc), 64'(pc));
            model_step(fetch(model_pc), expected, name);
            if (expected.valid) begin
                check_value(name, 64'(expected), 64'(retire));
            end else begin
                check_value(name, 64'(0), 64'(retire.valid));
            end
            @(negedge clk);
        end
        #(clk_period / 4);
        check_value("final pc", 64'(model_pc), 64'(pc));
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the core did not reach the end of the program in %0d cycles",
                     max_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire
